//--- common/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// widths and depths
`define NB_DATA       32
`define NB_REGADDR    5
`define IMEM_DEPTH    64
`define DMEM_DEPTH    64
`define NB_IMEM_ADDR  6
`define NB_DMEM_ADDR  6

// ----------------------------------------
// opcodes
`define OP_RTYPE      6'b000000
`define OP_ADDIU      6'b001001
`define OP_LW         6'b100011
`define OP_SW         6'b101011
`define OP_HALT       6'b111111   // all ones, drains the pipe

// function codes, R-type only
`define FN_ADDU       6'b100001
`define FN_SUBU       6'b100011
`define FN_AND        6'b100100
`define FN_OR         6'b100101
`define FN_SLT        6'b101010

`endif

//--- common/mipsPkg.sv
`include "mips_defines.svh"

package mipsPkg;

    // R-type field layout
    typedef struct packed {
        logic [5:0]             opcode;
        logic [`NB_REGADDR-1:0] rs;
        logic [`NB_REGADDR-1:0] rt;
        logic [`NB_REGADDR-1:0] rd;
        logic [4:0]             shamt;    // no shifts here
        logic [5:0]             func;
    } rType_s;

    // I-type field layout
    typedef struct packed {
        logic [5:0]             opcode;
        logic [`NB_REGADDR-1:0] rs;
        logic [`NB_REGADDR-1:0] rt;
        logic [15:0]            imm;
    } iType_s;

    // one instruction word, two views
    typedef union packed {
        rType_s r;
        iType_s i;
    } instr_u;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_e;

    typedef enum logic [1:0] {FWD_REG, FWD_EXMEM, FWD_MEMWB} fwdSel_e;

endpackage

//--- design/fetch/instrFetch.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module instrFetch (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_halt,       // global freeze
    input  logic                i_stall,      // load-use bubble
    input  logic                i_stop,       // halt opcode seen in decode
    input  logic                i_we,
    input  logic [`NB_DATA-1:0] i_instAddr,   // word index
    input  logic [`NB_DATA-1:0] i_instrData,
    output logic [`NB_DATA-1:0] o_instr
);

    logic [`NB_DATA-1:0]      instrMem [`IMEM_DEPTH];
    logic [`NB_IMEM_ADDR-1:0] pc;

    // program load port
    always_ff @(posedge clk) begin
        if (i_we) begin
            instrMem[i_instAddr[`NB_IMEM_ADDR-1:0]] <= i_instrData;
        end
    end

    // ----------------------------------------
    // pc and IF/ID register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc      <= '0;
            o_instr <= '0;                     // all zeros decodes as a nop
        end else if (!i_halt && !i_stall) begin
            if (i_stop) begin
                o_instr <= '0;                 // only bubbles behind the halt
            end else begin
                pc      <= pc + 1'b1;
                o_instr <= instrMem[pc];
            end
        end
    end

endmodule

//--- design/decode/instrDecode.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module instrDecode import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_halt,
    input  logic                   i_stall,
    input  instr_u                 i_instr,
    input  logic                   i_wbEn,
    input  logic [`NB_REGADDR-1:0] i_wbReg,
    input  logic [`NB_DATA-1:0]    i_wbData,
    output logic                   o_stop,
    output logic [`NB_DATA-1:0]    o_dataA,
    output logic [`NB_DATA-1:0]    o_dataB,
    output logic [`NB_DATA-1:0]    o_imm,
    output logic [`NB_REGADDR-1:0] o_rs,
    output logic [`NB_REGADDR-1:0] o_rt,
    output logic [`NB_REGADDR-1:0] o_dest,
    output aluOp_e                 o_aluOp,
    output logic                   o_aluSrcImm,
    output logic                   o_memRead,
    output logic                   o_memWrite,
    output logic                   o_regWrite,
    output logic                   o_halt
);

    logic [`NB_DATA-1:0]    regFile [2**`NB_REGADDR];
    logic [`NB_DATA-1:0]    readA, readB;
    logic [`NB_REGADDR-1:0] dest;
    aluOp_e                 aluOp;
    logic                   aluSrcImm, memRead, memWrite, regWrite, isHalt;
    logic                   stopReg;

    // reg 0 is hardwired, and a same-cycle write wins
    function automatic logic [`NB_DATA-1:0] readReg(input logic [`NB_REGADDR-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_wbEn && (i_wbReg == idx)) begin
            return i_wbData;
        end
        return regFile[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (i_wbEn && (i_wbReg != '0)) begin
            regFile[i_wbReg] <= i_wbData;
        end
    end

    always_comb begin
        readA = readReg(i_instr.r.rs);
        readB = readReg(i_instr.r.rt);
    end

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    always_comb begin
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        isHalt    = 1'b0;
        dest      = i_instr.i.rt;              // I-type writes rt
        case (i_instr.r.opcode)
            `OP_RTYPE: begin
                dest     = i_instr.r.rd;
                regWrite = 1'b1;
                case (i_instr.r.func)
                    `FN_ADDU: aluOp = ALU_ADD;
                    `FN_SUBU: aluOp = ALU_SUB;
                    `FN_AND:  aluOp = ALU_AND;
                    `FN_OR:   aluOp = ALU_OR;
                    `FN_SLT:  aluOp = ALU_SLT;
                    default:  regWrite = 1'b0;  // unknown func acts as nop
                endcase
            end
            `OP_ADDIU: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            `OP_LW: begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
            end
            `OP_SW: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            `OP_HALT: isHalt = 1'b1;
            default: ;
        endcase
    end

    // latches once the halt leaves IF/ID
    always_ff @(posedge clk) begin
        if (i_rst) begin
            stopReg <= 1'b0;
        end else if (isHalt && !i_stall && !i_halt) begin
            stopReg <= 1'b1;
        end
    end

    assign o_stop = stopReg | isHalt;

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_dataA <= readA;
            o_dataB <= readB;
            o_imm   <= {{(`NB_DATA-16){i_instr.i.imm[15]}}, i_instr.i.imm};
            o_rs    <= i_instr.r.rs;
            o_rt    <= i_instr.r.rt;
            o_dest  <= dest;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || (i_stall && !i_halt)) begin
            o_aluOp     <= ALU_ADD;            // bubble
            o_aluSrcImm <= 1'b0;
            o_memRead   <= 1'b0;
            o_memWrite  <= 1'b0;
            o_regWrite  <= 1'b0;
            o_halt      <= 1'b0;
        end else if (!i_halt) begin
            o_aluOp     <= aluOp;
            o_aluSrcImm <= aluSrcImm;
            o_memRead   <= memRead;
            o_memWrite  <= memWrite;
            o_regWrite  <= regWrite;
            o_halt      <= isHalt;
        end
    end

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module hazardUnit import mipsPkg::*; (
    input  logic [`NB_REGADDR-1:0] i_ifIdRs,
    input  logic [`NB_REGADDR-1:0] i_ifIdRt,
    input  logic [`NB_REGADDR-1:0] i_idExRt,
    input  logic                   i_idExMemRead,
    input  logic [`NB_REGADDR-1:0] i_idExRs,
    input  logic [`NB_REGADDR-1:0] i_exMemDest,
    input  logic                   i_exMemRegWrite,
    input  logic [`NB_REGADDR-1:0] i_memWbDest,
    input  logic                   i_memWbRegWrite,
    output logic                   o_stall,
    output fwdSel_e                o_fwdA,
    output fwdSel_e                o_fwdB
);

    // newest producer first
    function automatic fwdSel_e pickSource(input logic [`NB_REGADDR-1:0] src);
        if (i_exMemRegWrite && (i_exMemDest != '0) && (i_exMemDest == src)) begin
            return FWD_EXMEM;
        end
        if (i_memWbRegWrite && (i_memWbDest != '0) && (i_memWbDest == src)) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        o_fwdA  = pickSource(i_idExRs);
        o_fwdB  = pickSource(i_idExRt);
        // load result not ready until MEM/WB
        o_stall = i_idExMemRead && (i_idExRt != '0)
                  && ((i_idExRt == i_ifIdRs) || (i_idExRt == i_ifIdRt));
    end

endmodule

//--- design/execute/instrExecute.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module instrExecute import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_halt,
    input  logic [`NB_DATA-1:0]    i_dataA,
    input  logic [`NB_DATA-1:0]    i_dataB,
    input  logic [`NB_DATA-1:0]    i_imm,
    input  logic [`NB_REGADDR-1:0] i_dest,
    input  aluOp_e                 i_aluOp,
    input  logic                   i_aluSrcImm,
    input  logic                   i_memRead,
    input  logic                   i_memWrite,
    input  logic                   i_regWrite,
    input  logic                   i_haltFlag,
    input  fwdSel_e                i_fwdA,
    input  fwdSel_e                i_fwdB,
    input  logic [`NB_DATA-1:0]    i_memWbData,
    output logic [`NB_DATA-1:0]    o_result,
    output logic [`NB_DATA-1:0]    o_storeData,
    output logic [`NB_REGADDR-1:0] o_dest,
    output logic                   o_memRead,
    output logic                   o_memWrite,
    output logic                   o_regWrite,
    output logic                   o_haltFlag
);

    logic [`NB_DATA-1:0] opA, opB, aluB, aluOut;

    function automatic logic [`NB_DATA-1:0] pickOperand(
        input fwdSel_e             sel,
        input logic [`NB_DATA-1:0] regVal,
        input logic [`NB_DATA-1:0] exMemVal,
        input logic [`NB_DATA-1:0] memWbVal
    );
        case (sel)
            FWD_EXMEM: return exMemVal;
            FWD_MEMWB: return memWbVal;
            default:   return regVal;
        endcase
    endfunction

    assign opA  = pickOperand(i_fwdA, i_dataA, o_result, i_memWbData);
    assign opB  = pickOperand(i_fwdB, i_dataB, o_result, i_memWbData);
    assign aluB = i_aluSrcImm ? i_imm : opB;   // ADDIU, LW, SW take the imm

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (i_aluOp)
            ALU_SUB: aluOut = opA - aluB;
            ALU_AND: aluOut = opA & aluB;
            ALU_OR:  aluOut = opA | aluB;
            ALU_SLT: aluOut = {{(`NB_DATA-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluOut = opA + aluB;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_result    <= aluOut;
            o_storeData <= opB;                // forwarded rt for SW
            o_dest      <= i_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_memRead  <= 1'b0;
            o_memWrite <= 1'b0;
            o_regWrite <= 1'b0;
            o_haltFlag <= 1'b0;
        end else if (!i_halt) begin
            o_memRead  <= i_memRead;
            o_memWrite <= i_memWrite;
            o_regWrite <= i_regWrite;
            o_haltFlag <= i_haltFlag;
        end
    end

endmodule

//--- design/memory/memAccess.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module memAccess (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_halt,
    input  logic [`NB_DATA-1:0]    i_result,
    input  logic [`NB_DATA-1:0]    i_storeData,
    input  logic [`NB_REGADDR-1:0] i_dest,
    input  logic                   i_memRead,
    input  logic                   i_memWrite,
    input  logic                   i_regWrite,
    input  logic                   i_haltFlag,
    output logic                   o_wbEn,
    output logic [`NB_REGADDR-1:0] o_wbReg,
    output logic [`NB_DATA-1:0]    o_wbData,
    output logic                   o_end
);

    logic [`NB_DATA-1:0]      dataMem [`DMEM_DEPTH];
    logic [`NB_DMEM_ADDR-1:0] wordAddr;
    logic [`NB_DATA-1:0]      loadData, aluResult;
    logic                     memToReg, wbValid;

    assign wordAddr = i_result[`NB_DMEM_ADDR+1:2];   // byte address to word

    always_ff @(posedge clk) begin
        if (i_memWrite && !i_halt) begin
            dataMem[wordAddr] <= i_storeData;
        end
    end

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!i_halt) begin
            loadData  <= dataMem[wordAddr];
            aluResult <= i_result;
            o_wbReg   <= i_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wbValid  <= 1'b0;
            memToReg <= 1'b0;
            o_end    <= 1'b0;
        end else if (!i_halt) begin
            wbValid  <= i_regWrite && (i_dest != '0);  // no pulse for reg 0
            memToReg <= i_memRead;
            if (i_haltFlag) begin
                o_end <= 1'b1;                         // sticky
            end
        end
    end

    // a frozen write shows once, on release
    assign o_wbEn   = wbValid & ~i_halt;
    assign o_wbData = memToReg ? loadData : aluResult;

endmodule

//--- design/mipsPipeline.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsPipeline import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_we,
    input  logic [`NB_DATA-1:0]    i_instAddr,
    input  logic [`NB_DATA-1:0]    i_instrData,
    input  logic                   i_halt,
    output logic                   o_wbEn,
    output logic [`NB_REGADDR-1:0] o_wbReg,
    output logic [`NB_DATA-1:0]    o_wbData,
    output logic                   o_end
);

    instr_u                 instrIfId;
    logic                   stall, stop;
    fwdSel_e                fwdA, fwdB;

    // ID/EX
    logic [`NB_DATA-1:0]    dataAIdEx, dataBIdEx, immIdEx;
    logic [`NB_REGADDR-1:0] rsIdEx, rtIdEx, destIdEx;
    aluOp_e                 aluOpIdEx;
    logic                   aluSrcImmIdEx, memReadIdEx, memWriteIdEx;
    logic                   regWriteIdEx, haltIdEx;

    // EX/MEM
    logic [`NB_DATA-1:0]    resultExMem, storeDataExMem;
    logic [`NB_REGADDR-1:0] destExMem;
    logic                   memReadExMem, memWriteExMem, regWriteExMem, haltExMem;

    // ----------------------------------------
    instrFetch if0 (
        .clk(clk), .i_rst(i_rst), .i_halt(i_halt), .i_stall(stall), .i_stop(stop),
        .i_we(i_we), .i_instAddr(i_instAddr), .i_instrData(i_instrData),
        .o_instr(instrIfId)
    );

    instrDecode id0 (
        .clk(clk), .i_rst(i_rst), .i_halt(i_halt), .i_stall(stall),
        .i_instr(instrIfId),
        .i_wbEn(o_wbEn), .i_wbReg(o_wbReg), .i_wbData(o_wbData),   // WB back to regfile
        .o_stop(stop), .o_dataA(dataAIdEx), .o_dataB(dataBIdEx), .o_imm(immIdEx),
        .o_rs(rsIdEx), .o_rt(rtIdEx), .o_dest(destIdEx), .o_aluOp(aluOpIdEx),
        .o_aluSrcImm(aluSrcImmIdEx), .o_memRead(memReadIdEx), .o_memWrite(memWriteIdEx),
        .o_regWrite(regWriteIdEx), .o_halt(haltIdEx)
    );

    hazardUnit hz0 (
        .i_ifIdRs(instrIfId.r.rs), .i_ifIdRt(instrIfId.r.rt),
        .i_idExRt(rtIdEx), .i_idExMemRead(memReadIdEx), .i_idExRs(rsIdEx),
        .i_exMemDest(destExMem), .i_exMemRegWrite(regWriteExMem),
        .i_memWbDest(o_wbReg), .i_memWbRegWrite(o_wbEn),
        .o_stall(stall), .o_fwdA(fwdA), .o_fwdB(fwdB)
    );

    instrExecute ex0 (
        .clk(clk), .i_rst(i_rst), .i_halt(i_halt),
        .i_dataA(dataAIdEx), .i_dataB(dataBIdEx), .i_imm(immIdEx), .i_dest(destIdEx),
        .i_aluOp(aluOpIdEx), .i_aluSrcImm(aluSrcImmIdEx), .i_memRead(memReadIdEx),
        .i_memWrite(memWriteIdEx), .i_regWrite(regWriteIdEx), .i_haltFlag(haltIdEx),
        .i_fwdA(fwdA), .i_fwdB(fwdB), .i_memWbData(o_wbData),
        .o_result(resultExMem), .o_storeData(storeDataExMem), .o_dest(destExMem),
        .o_memRead(memReadExMem), .o_memWrite(memWriteExMem),
        .o_regWrite(regWriteExMem), .o_haltFlag(haltExMem)
    );

    memAccess mem0 (
        .clk(clk), .i_rst(i_rst), .i_halt(i_halt),
        .i_result(resultExMem), .i_storeData(storeDataExMem), .i_dest(destExMem),
        .i_memRead(memReadExMem), .i_memWrite(memWriteExMem),
        .i_regWrite(regWriteExMem), .i_haltFlag(haltExMem),
        .o_wbEn(o_wbEn), .o_wbReg(o_wbReg), .o_wbData(o_wbData), .o_end(o_end)
    );

endmodule

//--- verification/wbChecker.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module wbChecker (
    input  logic                   clk,
    input  logic                   i_wbEn,
    input  logic [`NB_REGADDR-1:0] i_wbReg,
    input  logic [`NB_DATA-1:0]    i_wbData,
    input  logic                   i_end,
    output int                     o_seen,
    output int                     o_errors,
    output int                     o_endErrors,
    output int                     o_groupsRun,
    output int                     o_groupsFailed,
    output int                     o_pending,
    output logic                   o_endSeen
);

    logic [`NB_REGADDR-1:0] expReg [$];
    logic [`NB_DATA-1:0]    expData [$];
    int                     expGrp [$];
    int                     grpErrors;

    initial begin
        o_seen         = 0;
        o_errors       = 0;
        o_endErrors    = 0;
        o_groupsRun    = 0;
        o_groupsFailed = 0;
        o_endSeen      = 1'b0;
        grpErrors      = 0;
    end

    // one expected write-back, in program order
    task automatic addExpected(input int grp, input int regIdx, input logic [`NB_DATA-1:0] val);
        expGrp.push_back(grp);
        expReg.push_back(regIdx[`NB_REGADDR-1:0]);
        expData.push_back(val);
        o_pending = expGrp.size();
    endtask

    function automatic string groupName(input int g);
        case (g)
            1:       return "R-type ALU";
            2:       return "immediates";
            3:       return "forwarding";
            4:       return "load-use";
            5:       return "freeze";
            6:       return "register 0";
            default: return "unnamed";
        endcase
    endfunction

    // ----------------------------------------
    // outputs settle well before the falling edge
    always @(negedge clk) begin : sampleWb
        int                     g;
        logic [`NB_REGADDR-1:0] er;
        logic [`NB_DATA-1:0]    ed;
        if (i_wbEn === 1'b1) begin
            if (expGrp.size() == 0) begin
                $display("unexpected write-back to register %0d, no entry left", i_wbReg);
                o_errors++;
                if (o_endSeen) begin
                    o_endErrors++;                 // pulse after the drain
                end
            end else begin
                g  = expGrp.pop_front();
                er = expReg.pop_front();
                ed = expData.pop_front();
                if (i_wbReg !== er) begin
                    $display("[ERROR] o_wbReg expected 0x%h got 0x%h", er, i_wbReg);
                    grpErrors++;
                    o_errors++;
                end
                if (i_wbData !== ed) begin
                    $display("[ERROR] o_wbData expected 0x%h got 0x%h", ed, i_wbData);
                    grpErrors++;
                    o_errors++;
                end
                o_seen++;
                // last entry of this group
                if (expGrp.size() == 0 || expGrp[0] != g) begin
                    $display("test %0d %s: %s", g, groupName(g), (grpErrors == 0) ? "PASS" : "FAIL");
                    o_groupsRun++;
                    if (grpErrors != 0) begin
                        o_groupsFailed++;
                    end
                    grpErrors = 0;
                end
            end
            o_pending = expGrp.size();
        end
        if (i_end === 1'b1 && !o_endSeen) begin
            o_endSeen = 1'b1;
            if (expGrp.size() != 0) begin
                $display("o_end rose with %0d expected write-backs outstanding", expGrp.size());
                o_errors++;
                o_endErrors++;
            end
        end
    end

endmodule

//--- verification/tbPipeline.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module tbPipeline;

    localparam int WAIT_TIMEOUT = 200;
    localparam int END_TIMEOUT  = 300;
    localparam int FREEZE_GRP   = 5;   // test whose writes are in flight during the freeze

    logic                   clk;
    logic                   rst, we, halt;
    logic [`NB_DATA-1:0]    instAddr, instrData;
    logic                   wbEn, endFlag;
    logic [`NB_REGADDR-1:0] wbReg;
    logic [`NB_DATA-1:0]    wbData;

    logic [`NB_DATA-1:0]    progAddr [$];
    logic [`NB_DATA-1:0]    progWord [$];
    int                     seenCount, errCount, endErrCount, groupsRun, groupsFailed, pending;
    logic                   endSeen;
    int                     tbErrors, freezeAt;

    mipsPipeline dut0 (
        .clk(clk), .i_rst(rst), .i_we(we), .i_instAddr(instAddr), .i_instrData(instrData),
        .i_halt(halt), .o_wbEn(wbEn), .o_wbReg(wbReg), .o_wbData(wbData), .o_end(endFlag)
    );

    wbChecker chk0 (
        .clk(clk), .i_wbEn(wbEn), .i_wbReg(wbReg), .i_wbData(wbData), .i_end(endFlag),
        .o_seen(seenCount), .o_errors(errCount), .o_endErrors(endErrCount),
        .o_groupsRun(groupsRun), .o_groupsFailed(groupsFailed), .o_pending(pending),
        .o_endSeen(endSeen)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // P lines fill the program and E lines go to the checker
    task automatic readStim();
        int                  fd, n, ch, grp, regIdx;
        logic [7:0]          tag;
        logic [`NB_DATA-1:0] a, d;
        fd = $fopen("verification/pipeline_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/pipeline_stim.txt");
            tbErrors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                break;
            end
            if (tag == "#") begin
                ch = 0;
                while (ch != 8'h0a && ch != -1) begin
                    ch = $fgetc(fd);              // rest of a comment
                end
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h %h", a, d);
                progAddr.push_back(a);
                progWord.push_back(d);
            end else if (tag == "E") begin
                n = $fscanf(fd, "%d %d %h", grp, regIdx, d);
                chk0.addExpected(grp, regIdx, d);
                if (grp < FREEZE_GRP) begin
                    freezeAt++;
                end
            end else begin
                $display("unknown line tag '%c' in stim file", tag);
                tbErrors++;
                break;
            end
        end
        $fclose(fd);
    endtask

    task automatic loadProgram();
        logic [15:0] idx;
        // fill words write r20 if fetch runs past the halt
        for (int k = 0; k < `IMEM_DEPTH; k++) begin
            idx = k[15:0];
            @(posedge clk);
            #1;
            we        = 1'b1;
            instAddr  = k;
            instrData = {`OP_ADDIU, 5'd0, 5'd20, idx};
        end
        for (int k = 0; k < progAddr.size(); k++) begin
            @(posedge clk);
            #1;
            we        = 1'b1;
            instAddr  = progAddr[k];
            instrData = progWord[k];
        end
        @(posedge clk);
        #1 we = 1'b0;
    endtask

    // called right after a rising edge
    task automatic freezeFor(input int cycles);
        #1 halt = 1'b1;
        repeat (cycles) @(posedge clk);
        #1 halt = 1'b0;
    endtask

    // ----------------------------------------
    initial begin : runTest
        int cyc;
        logic haltOk;
        rst       = 1'b1;
        we        = 1'b0;
        halt      = 1'b1;                         // frozen while loading
        instAddr  = '0;
        instrData = '0;
        tbErrors  = 0;
        freezeAt  = 0;
        readStim();
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        loadProgram();
        @(posedge clk);
        #1 halt = 1'b0;

        cyc = 0;
        while (seenCount < freezeAt && cyc < WAIT_TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (seenCount < freezeAt) begin
            $display("timeout waiting for %0d write-backs before the freeze", freezeAt);
            tbErrors++;
        end
        freezeFor(3);
        @(posedge clk);
        freezeFor(2);

        cyc = 0;
        while (!endSeen && cyc < END_TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (!endSeen) begin
            $display("timeout, o_end did not rise within %0d cycles", END_TIMEOUT);
            tbErrors++;
        end
        repeat (10) @(posedge clk);               // stray pulses after the drain
        haltOk = endSeen && (endErrCount == 0) && (pending == 0);
        $display("test 7 halt drain: %s", haltOk ? "PASS" : "FAIL");
        if (pending != 0) begin
            $display("%0d expected write-backs never arrived", pending);
        end
        $display("summary: %0d tests, %0d failed, %0d write-backs checked, %0d errors",
                 groupsRun + 1, groupsFailed + (haltOk ? 0 : 1), seenCount,
                 errCount + tbErrors);
        if (errCount == 0 && tbErrors == 0 && haltOk) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/mipsPkg.sv
design/fetch/instrFetch.sv
design/decode/instrDecode.sv
design/hazardUnit.sv
design/execute/instrExecute.sv
design/memory/memAccess.sv
design/mipsPipeline.sv
verification/wbChecker.sv
verification/tbPipeline.sv

//--- verification/pipeline_stim.txt
# P <word index, hex> <instruction, hex>
# E <test number> <dest register, decimal> <write-back value, hex>, in program order
P 00 24010015  # addiu r1, r0, 0x15
P 01 24020007  # addiu r2, r0, 7
P 02 00221821  # addu r3, r1, r2
P 03 00222023  # subu r4, r1, r2
P 04 00642824  # and r5, r3, r4
P 05 00643025  # or r6, r3, r4
P 06 0041382a  # slt r7, r2, r1
P 07 2428fff0  # addiu r8, r1, -16
P 08 24098000  # addiu r9, r0, -32768
P 09 0128502a  # slt r10, r9, r8
P 0a 240b0003  # addiu r11, r0, 3
P 0b 016b6021  # addu r12, r11, r11
P 0c 018b6823  # subu r13, r12, r11
P 0d ac0c0008  # sw r12, 8(r0)
P 0e 8c0e0008  # lw r14, 8(r0)
P 0f 01cd7821  # addu r15, r14, r13
P 10 25f00010  # addiu r16, r15, 0x10
P 11 02018825  # or r17, r16, r1
P 12 02309023  # subu r18, r17, r16
P 13 24200055  # addiu r0, r1, 0x55
P 14 00029821  # addu r19, r0, r2
P 15 fc000000  # halt
E 1 1 00000015
E 1 2 00000007
E 1 3 0000001c
E 1 4 0000000e
E 1 5 0000000c
E 1 6 0000001e
E 1 7 00000001
E 2 8 00000005
E 2 9 ffff8000
E 2 10 00000001
E 3 11 00000003
E 3 12 00000006
E 3 13 00000003
E 4 14 00000006
E 4 15 00000009
E 5 16 00000019
E 5 17 0000001d
E 5 18 00000004
E 6 19 00000007
